// File: project.f
+incdir+dv
common/decode_pkg.sv
decoder/inst_decode.sv
decoder/branch_classify.sv
verilog/apb_ctrl_fsm.sv
verilog/decode_stats.sv
verilog/decode_regs.sv
verilog/apb_decoder_top.sv
dv/decoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decoder_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass message in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/decode_vectors.svh
// decode stimulus table
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns are pc, instruction word, op, cf, use_imm, imm_signed, is_load, is_store,
// is_multicyc, rs1, rs2 and rd
typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    op_t         op;
    cf_t         cf;
    logic        use_imm;
    logic        imm_signed;
    logic        is_load;
    logic        is_store;
    logic        is_multicyc;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
} vec_t;

localparam int NUM_VECTORS = 25;

vec_t vectors [NUM_VECTORS] = '{
    '{32'h0040_0000, 32'h0022_1820, OP_ADD,     CF_NONE,   0, 1, 0, 0, 0, 5'd1,  5'd2,  5'd3},
    '{32'h0040_0004, 32'h0005_20C3, OP_SRA,     CF_NONE,   0, 1, 0, 0, 0, 5'd0,  5'd5,  5'd4},
    '{32'h0040_0008, 32'h00C7_0018, OP_MULT,    CF_NONE,   0, 1, 0, 0, 1, 5'd6,  5'd7,  5'd0},
    '{32'h0040_000C, 32'h0100_0011, OP_MTHI,    CF_NONE,   0, 1, 0, 0, 1, 5'd8,  5'd0,  5'd0},
    '{32'h0040_0010, 32'h2149_FFF0, OP_ADD,     CF_NONE,   1, 1, 0, 0, 0, 5'd10, 5'd0,  5'd9},
    '{32'h0040_0014, 32'h3422_1234, OP_OR,      CF_NONE,   1, 0, 0, 0, 0, 5'd1,  5'd0,  5'd2},
    '{32'h0040_0018, 32'h3C0B_ABCD, OP_LUI,     CF_NONE,   1, 0, 0, 0, 0, 5'd0,  5'd0,  5'd11},
    '{32'h0040_001C, 32'h8FA8_0010, OP_LW,      CF_NONE,   0, 1, 1, 0, 0, 5'd29, 5'd0,  5'd8},
    '{32'h0040_0020, 32'h9085_0003, OP_LBU,     CF_NONE,   0, 1, 1, 0, 0, 5'd4,  5'd0,  5'd5},
    '{32'h0040_0024, 32'hA46C_FFFC, OP_SH,      CF_NONE,   0, 1, 0, 1, 0, 5'd3,  5'd12, 5'd0},
    '{32'h0040_0028, 32'h1022_0008, OP_BEQ,     CF_BRANCH, 0, 1, 0, 0, 0, 5'd1,  5'd2,  5'd0},
    '{32'h0040_002C, 32'h04B0_FFFE, OP_BLTZAL,  CF_BRANCH, 1, 1, 0, 0, 0, 5'd5,  5'd0,  5'd31},
    '{32'h0040_0030, 32'h0810_0040, OP_JAL,     CF_JUMP,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd0},
    '{32'h0040_0034, 32'h0C00_0123, OP_JAL,     CF_CALL,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd31},
    '{32'h0040_0038, 32'h4004_6000, OP_MFC0,    CF_NONE,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd4},
    '{32'h0040_003C, 32'h4086_6000, OP_MTC0,    CF_NONE,   0, 1, 0, 0, 0, 5'd6,  5'd0,  5'd0},
    '{32'h0040_0040, 32'h4200_0018, OP_ERET,    CF_NONE,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd0},
    '{32'h8000_0100, 32'h03E0_0008, OP_JALR,    CF_RETURN, 0, 1, 0, 0, 0, 5'd31, 5'd0,  5'd0},
    '{32'h8000_0104, 32'h0080_F809, OP_JALR,    CF_CALL,   0, 1, 0, 0, 0, 5'd4,  5'd0,  5'd31},
    '{32'h8000_0108, 32'h1464_FFFF, OP_BNE,     CF_BRANCH, 0, 1, 0, 0, 0, 5'd3,  5'd4,  5'd0},
    '{32'h0040_0100, 32'h0022_183F, OP_INVALID, CF_NONE,   0, 1, 0, 0, 0, 5'd1,  5'd2,  5'd3},
    '{32'h0040_0104, 32'hFC00_0000, OP_INVALID, CF_NONE,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd0},
    '{32'h0040_0108, 32'h43E0_0000, OP_INVALID, CF_NONE,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd0},
    '{32'h0040_010C, 32'h9C43_0000, OP_INVALID, CF_NONE,   0, 1, 1, 0, 0, 5'd2,  5'd0,  5'd3},
    '{32'h0040_0110, 32'h7022_1802, OP_INVALID, CF_NONE,   0, 1, 0, 0, 0, 5'd0,  5'd0,  5'd0}
};

`endif

// File: dv/decoder_tb.sv
// decoder testbench
`timescale 1ns/1ps
`default_nettype none

module decoder_tb import decode_pkg::*; ();

    `include "decode_vectors.svh"

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;
    logic [31:0] rng_state;
    int          exp_branch;
    int          exp_mem;
    int          exp_invalid;
    int          exp_total;

    apb_decoder_top #(
        .APB_ADDR_WIDTH (8),
        .STAT_WIDTH     (16)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected 0x%08h actual 0x%08h",
                     $time, name, exp, act);
            errors++;
        end
    endtask

    // one full transfer completing in its third cycle
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        while (!pready && waits < 10) begin
            @(posedge clk);
            #1;
            waits++;
        end
        if (!pready) begin
            $display("timeout: pready never rose for access to offset 0x%02h", addr);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            if (waits != 1) begin
                $display("transfer to 0x%02h took %0d wait cycles instead of one",
                         addr, waits);
                errors++;
            end
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_transfer(1'b1, addr, data, unused, err);
        check_value($sformatf("pslverr write 0x%02h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        apb_transfer(1'b0, addr, 32'h0, data, err);
        check_value($sformatf("pslverr read 0x%02h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        reg_read(addr, data, 1'b0);
        check_value(name, exp, data);
    endtask

    // expected targets from the branch and jump formulas
    function automatic logic [31:0] branch_target(input logic [31:0] pc,
                                                  input logic [31:0] word);
        int offset;
        offset = int'($signed(word[15:0]));
        return pc + 32'd4 + 32'(offset * 4);
    endfunction

    function automatic logic [31:0] jump_target(input logic [31:0] pc,
                                                input logic [31:0] word);
        logic [31:0] next_pc;
        next_pc = pc + 32'd4;
        return {next_pc[31:28], word[25:0], 2'b00};
    endfunction

    task automatic run_vector(input int idx, input logic [31:0] pc);
        vec_t        v;
        logic [31:0] exp_op;
        logic [31:0] exp_regs;
        v        = vectors[idx];
        exp_op   = {16'b0, v.is_multicyc, v.is_store, v.is_load, v.imm_signed,
                    v.use_imm, v.cf, 1'b0, v.op};
        exp_regs = {11'b0, v.rd, 3'b0, v.rs2, 3'b0, v.rs1};
        reg_write(REG_PC, pc, 1'b0);
        reg_write(REG_INST, v.inst, 1'b0);
        read_expect("REG_PC", REG_PC, pc);
        read_expect("REG_DEC_OP", REG_DEC_OP, exp_op);
        read_expect("REG_DEC_REGS", REG_DEC_REGS, exp_regs);
        read_expect("REG_JUMP_I", REG_JUMP_I, branch_target(pc, v.inst));
        read_expect("REG_JUMP_J", REG_JUMP_J, jump_target(pc, v.inst));
        exp_total++;
        if (v.cf == CF_BRANCH) exp_branch++;
        if (v.is_load || v.is_store) exp_mem++;
        if (v.op == OP_INVALID) exp_invalid++;
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("test %-16s [errors %0d]", name, errors - test_start_errors);
        end else begin
            $display("test %-16s [ok]", name);
        end
    endtask

    initial begin
        logic [31:0] data;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        reset        = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rng_state    = 32'd67418;
        exp_branch   = 0;
        exp_mem      = 0;
        exp_invalid  = 0;
        exp_total    = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test();
        read_expect("REG_PC", REG_PC, 32'h0);
        read_expect("REG_INST", REG_INST, 32'h0);
        read_expect("REG_DEC_OP", REG_DEC_OP, 32'h0);
        read_expect("REG_DEC_REGS", REG_DEC_REGS, 32'h0);
        read_expect("REG_JUMP_I", REG_JUMP_I, 32'h4); // zero pc plus 4
        read_expect("REG_JUMP_J", REG_JUMP_J, 32'h0);
        read_expect("REG_STAT_BRANCH", REG_STAT_BRANCH, 32'h0);
        read_expect("REG_STAT_MEM", REG_STAT_MEM, 32'h0);
        read_expect("REG_STAT_INVALID", REG_STAT_INVALID, 32'h0);
        read_expect("REG_STAT_TOTAL", REG_STAT_TOTAL, 32'h0);
        end_test("reset_values");

        begin_test();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i, vectors[i].pc);
        end
        end_test("decode_table");

        begin_test();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            rng_state = xorshift32(rng_state);
            run_vector(i, {rng_state[31:2], 2'b00});
        end
        end_test("random_targets");

        begin_test();
        read_expect("REG_STAT_BRANCH", REG_STAT_BRANCH, 32'(exp_branch));
        read_expect("REG_STAT_MEM", REG_STAT_MEM, 32'(exp_mem));
        read_expect("REG_STAT_INVALID", REG_STAT_INVALID, 32'(exp_invalid));
        read_expect("REG_STAT_TOTAL", REG_STAT_TOTAL, 32'(exp_total));
        reg_write(REG_STAT_TOTAL, 32'h0, 1'b0);
        read_expect("REG_STAT_BRANCH", REG_STAT_BRANCH, 32'h0);
        read_expect("REG_STAT_MEM", REG_STAT_MEM, 32'h0);
        read_expect("REG_STAT_INVALID", REG_STAT_INVALID, 32'h0);
        read_expect("REG_STAT_TOTAL", REG_STAT_TOTAL, 32'h0);
        end_test("statistics");

        begin_test();
        reg_read(8'h40, data, 1'b1); // unmapped
        reg_write(REG_DEC_OP, 32'hFFFF_FFFF, 1'b1); // read only
        reg_write(REG_JUMP_J, 32'h1234_5678, 1'b1);
        read_expect("REG_STAT_TOTAL", REG_STAT_TOTAL, 32'h0);
        end_test("bus_errors");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/apb_decoder_top.sv
// apb instruction decoder top
`timescale 1ns/1ps
`default_nettype none

module apb_decoder_top import decode_pkg::*; #(
    parameter int APB_ADDR_WIDTH = 8,
    parameter int STAT_WIDTH     = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [XLEN-1:0]           pwdata,
    output logic [XLEN-1:0]           prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic                  access_strobe;
    logic                  capture_strobe;
    logic                  stat_clear;
    inst_u                 inst;
    logic [XLEN-1:0]       pc;
    op_t                   op;
    reg_addr_t             rs1;
    reg_addr_t             rs2;
    reg_addr_t             rd;
    logic                  use_imm;
    logic                  imm_signed;
    logic                  is_load;
    logic                  is_store;
    logic                  is_multicyc;
    cf_t                   cf;
    logic [XLEN-1:0]       jump_i;
    logic [XLEN-1:0]       jump_j;
    logic [STAT_WIDTH-1:0] stat_branch;
    logic [STAT_WIDTH-1:0] stat_mem;
    logic [STAT_WIDTH-1:0] stat_invalid;
    logic [STAT_WIDTH-1:0] stat_total;

    apb_ctrl_fsm ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .access_strobe (access_strobe),
        .pready        (pready)
    );

    decode_regs #(
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH),
        .STAT_WIDTH     (STAT_WIDTH)
    ) regs_i (
        .clk            (clk),
        .reset          (reset),
        .access_strobe  (access_strobe),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .op             (op),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .use_imm        (use_imm),
        .imm_signed     (imm_signed),
        .is_load        (is_load),
        .is_store       (is_store),
        .is_multicyc    (is_multicyc),
        .cf             (cf),
        .jump_i         (jump_i),
        .jump_j         (jump_j),
        .stat_branch    (stat_branch),
        .stat_mem       (stat_mem),
        .stat_invalid   (stat_invalid),
        .stat_total     (stat_total),
        .inst           (inst),
        .pc             (pc),
        .capture_strobe (capture_strobe),
        .stat_clear     (stat_clear),
        .prdata         (prdata),
        .pslverr        (pslverr)
    );

    inst_decode decode_i (
        .inst        (inst),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .use_imm     (use_imm),
        .imm_signed  (imm_signed),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_multicyc (is_multicyc)
    );

    branch_classify branch_i (
        .inst   (inst),
        .pc     (pc),
        .cf     (cf),
        .jump_i (jump_i),
        .jump_j (jump_j)
    );

    decode_stats #(
        .STAT_WIDTH (STAT_WIDTH)
    ) stats_i (
        .clk            (clk),
        .reset          (reset),
        .capture_strobe (capture_strobe),
        .stat_clear     (stat_clear),
        .op             (op),
        .is_load        (is_load),
        .is_store       (is_store),
        .cf             (cf),
        .stat_branch    (stat_branch),
        .stat_mem       (stat_mem),
        .stat_invalid   (stat_invalid),
        .stat_total     (stat_total)
    );

endmodule

`default_nettype wire

// File: verilog/decode_regs.sv
// host visible register block
`timescale 1ns/1ps
`default_nettype none

module decode_regs import decode_pkg::*; #(
    parameter int APB_ADDR_WIDTH = 8,
    parameter int STAT_WIDTH     = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      access_strobe,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [XLEN-1:0]           pwdata,
    input  op_t                       op,
    input  reg_addr_t                 rs1,
    input  reg_addr_t                 rs2,
    input  reg_addr_t                 rd,
    input  logic                      use_imm,
    input  logic                      imm_signed,
    input  logic                      is_load,
    input  logic                      is_store,
    input  logic                      is_multicyc,
    input  cf_t                       cf,
    input  logic [XLEN-1:0]           jump_i,
    input  logic [XLEN-1:0]           jump_j,
    input  logic [STAT_WIDTH-1:0]     stat_branch,
    input  logic [STAT_WIDTH-1:0]     stat_mem,
    input  logic [STAT_WIDTH-1:0]     stat_invalid,
    input  logic [STAT_WIDTH-1:0]     stat_total,
    output inst_u                     inst,
    output logic [XLEN-1:0]           pc,
    output logic                      capture_strobe,
    output logic                      stat_clear,
    output logic [XLEN-1:0]           prdata,
    output logic                      pslverr
);

    logic [XLEN-1:0] dec_op_q;
    logic [XLEN-1:0] dec_regs_q;
    logic [XLEN-1:0] jump_i_q;
    logic [XLEN-1:0] jump_j_q;
    logic [XLEN-1:0] rdata;
    logic            err;
    logic            wr;

    assign wr         = access_strobe && pwrite;
    assign stat_clear = wr && (paddr == APB_ADDR_WIDTH'(REG_STAT_TOTAL));

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (paddr)
            APB_ADDR_WIDTH'(REG_PC):           rdata = pc;
            APB_ADDR_WIDTH'(REG_INST):         rdata = '0; // write only
            APB_ADDR_WIDTH'(REG_DEC_OP):       rdata = dec_op_q;
            APB_ADDR_WIDTH'(REG_DEC_REGS):     rdata = dec_regs_q;
            APB_ADDR_WIDTH'(REG_JUMP_I):       rdata = jump_i_q;
            APB_ADDR_WIDTH'(REG_JUMP_J):       rdata = jump_j_q;
            APB_ADDR_WIDTH'(REG_STAT_BRANCH):  rdata = XLEN'(stat_branch);
            APB_ADDR_WIDTH'(REG_STAT_MEM):     rdata = XLEN'(stat_mem);
            APB_ADDR_WIDTH'(REG_STAT_INVALID): rdata = XLEN'(stat_invalid);
            APB_ADDR_WIDTH'(REG_STAT_TOTAL):   rdata = XLEN'(stat_total);
            default:                           err   = 1'b1;
        endcase
        // only pc, inst and the clear register take writes
        if (pwrite && !err && paddr != APB_ADDR_WIDTH'(REG_PC)
                && paddr != APB_ADDR_WIDTH'(REG_INST)
                && paddr != APB_ADDR_WIDTH'(REG_STAT_TOTAL)) begin
            err = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc             <= '0;
            inst           <= '0;
            capture_strobe <= 1'b0;
            prdata         <= '0;
            pslverr        <= 1'b0;
        end else begin
            capture_strobe <= wr && (paddr == APB_ADDR_WIDTH'(REG_INST));
            if (wr && paddr == APB_ADDR_WIDTH'(REG_PC)) begin
                pc <= pwdata;
            end
            if (wr && paddr == APB_ADDR_WIDTH'(REG_INST)) begin
                inst <= pwdata;
            end
            if (access_strobe) begin
                prdata  <= pwrite ? '0 : rdata;
                pslverr <= err;
            end
        end
    end

    // decode result one edge after the instruction lands
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_op_q   <= '0;
            dec_regs_q <= '0;
            jump_i_q   <= 32'd4; // target of zero pc and zero word
            jump_j_q   <= '0;
        end else if (capture_strobe) begin
            dec_op_q   <= {16'b0, is_multicyc, is_store, is_load, imm_signed,
                           use_imm, cf, 1'b0, op};
            dec_regs_q <= {11'b0, rd, 3'b0, rs2, 3'b0, rs1};
            jump_i_q   <= jump_i;
            jump_j_q   <= jump_j;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_stats.sv
// decode statistics counters
`timescale 1ns/1ps
`default_nettype none

module decode_stats import decode_pkg::*; #(
    parameter int STAT_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  capture_strobe,
    input  logic                  stat_clear,
    input  op_t                   op,
    input  logic                  is_load,
    input  logic                  is_store,
    input  cf_t                   cf,
    output logic [STAT_WIDTH-1:0] stat_branch,
    output logic [STAT_WIDTH-1:0] stat_mem,
    output logic [STAT_WIDTH-1:0] stat_invalid,
    output logic [STAT_WIDTH-1:0] stat_total
);

    logic [3:0][STAT_WIDTH-1:0] cnt;
    logic [3:0]                 hit;

    assign hit = {1'b1, op == OP_INVALID, is_load | is_store, cf == CF_BRANCH};

    always_ff @(posedge clk) begin
        if (reset || stat_clear) begin
            cnt <= '0;
        end else if (capture_strobe) begin
            for (int i = 0; i < 4; i++) begin
                if (hit[i] && !(&cnt[i])) begin // hold at max
                    cnt[i] <= cnt[i] + STAT_WIDTH'(1);
                end
            end
        end
    end

    assign stat_branch  = cnt[0];
    assign stat_mem     = cnt[1];
    assign stat_invalid = cnt[2];
    assign stat_total   = cnt[3];

endmodule

`default_nettype wire

// File: verilog/apb_ctrl_fsm.sv
// apb transfer sequencer
`timescale 1ns/1ps
`default_nettype none

module apb_ctrl_fsm (
    input  logic clk,
    input  logic reset,
    input  logic psel,
    input  logic penable,
    output logic access_strobe,
    output logic pready
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_WAIT  = 2'd1;
    localparam logic [1:0] S_READY = 2'd2;

    logic [1:0] state;

    // first access cycle seen from idle
    assign access_strobe = (state == S_IDLE) && psel && penable;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            pready <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (access_strobe) begin
                        state  <= S_WAIT;
                        pready <= 1'b1; // data registered by now
                    end
                end
                S_WAIT: begin
                    state  <= S_READY;
                    pready <= 1'b0;
                end
                S_READY: state <= S_IDLE; // next setup may overlap
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: decoder/branch_classify.sv
// control flow class and targets
`timescale 1ns/1ps
`default_nettype none

module branch_classify import decode_pkg::*; (
    input  inst_u            inst,
    input  logic [XLEN-1:0]  pc,
    output cf_t              cf,
    output logic [XLEN-1:0]  jump_i,
    output logic [XLEN-1:0]  jump_j
);

    logic [XLEN-1:0] pc_plus4;
    logic            is_regimm_br;
    logic            is_branch;
    logic            is_jump_i;
    logic            is_jump_r;
    logic            is_call;
    logic            is_return;

    assign pc_plus4 = pc + 32'd4;
    assign jump_i   = pc_plus4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
    assign jump_j   = {pc_plus4[31:28], inst.r.rs, inst.r.rt, inst.r.rd,
                       inst.r.shamt, inst.r.funct, 2'b00}; // 26 bit index

    assign is_regimm_br = (inst.i.opcode == 6'b000001) && (inst.i.rt[3:1] == 3'b000);
    assign is_branch    = (inst.i.opcode[5:2] == 4'b0001) || is_regimm_br;
    assign is_jump_i    = (inst.r.opcode[5:1] == 5'b00001);
    assign is_jump_r    = (inst.r.opcode == 6'b000000) && (inst.r.funct[5:1] == 5'b00100);
    assign is_call      = (inst.r.opcode == 6'b000011)
                        || (is_regimm_br && inst.i.rt[4])
                        || (is_jump_r && inst.r.rd == 5'd31);
    assign is_return    = is_jump_r && !inst.r.funct[0] && inst.r.rs == 5'd31; // jr $ra

    always_comb begin
        unique casez ({is_branch, is_return, is_call, is_jump_i | is_jump_r})
            4'b1???: cf = CF_BRANCH;
            4'b01??: cf = CF_RETURN;
            4'b001?: cf = CF_CALL;
            4'b0001: cf = CF_JUMP;
            default: cf = CF_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: decoder/inst_decode.sv
// instruction field decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decode import decode_pkg::*; (
    input  inst_u     inst,
    output op_t       op,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output logic      use_imm,
    output logic      imm_signed,
    output logic      is_load,
    output logic      is_store,
    output logic      is_multicyc
);

    always_comb begin
        op          = OP_SLL;
        rs1         = '0;
        rs2         = '0;
        rd          = '0;
        use_imm     = 1'b0;
        imm_signed  = 1'b1;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_multicyc = 1'b0;

        unique casez (inst.r.opcode)
            6'b000000: begin // SPECIAL
                rs1 = inst.r.rs;
                rs2 = inst.r.rt;
                rd  = inst.r.rd;
                unique casez (inst.r.funct)
                    6'b0110??: is_multicyc = 1'b1; // mult/div
                    6'b0100?1: is_multicyc = 1'b1; // mthi/mtlo
                    default:   is_multicyc = 1'b0;
                endcase
                unique case (inst.r.funct)
                    6'b000000: op = OP_SLL;
                    6'b000010: op = OP_SRL;
                    6'b000011: op = OP_SRA;
                    6'b000100: op = OP_SLLV;
                    6'b000110: op = OP_SRLV;
                    6'b000111: op = OP_SRAV;
                    6'b001000: op = OP_JALR; // jr
                    6'b001001: op = OP_JALR;
                    6'b001100: op = OP_SYSCALL;
                    6'b001101: op = OP_BREAK;
                    6'b010000: op = OP_MFHI;
                    6'b010001: op = OP_MTHI;
                    6'b010010: op = OP_MFLO;
                    6'b010011: op = OP_MTLO;
                    6'b011000: op = OP_MULT;
                    6'b011001: op = OP_MULTU;
                    6'b011010: op = OP_DIV;
                    6'b011011: op = OP_DIVU;
                    6'b100000: op = OP_ADD;
                    6'b100001: op = OP_ADDU;
                    6'b100010: op = OP_SUB;
                    6'b100011: op = OP_SUBU;
                    6'b100100: op = OP_AND;
                    6'b100101: op = OP_OR;
                    6'b100110: op = OP_XOR;
                    6'b100111: op = OP_NOR;
                    6'b101010: op = OP_SLT;
                    6'b101011: op = OP_SLTU;
                    default:   op = OP_INVALID;
                endcase
            end

            6'b000001: begin // REGIMM
                rs1     = inst.i.rs;
                rd      = (inst.i.rt[4:1] == 4'b1000) ? 5'd31 : 5'd0; // link forms
                use_imm = 1'b1;
                unique case (inst.i.rt)
                    5'b00000: op = OP_BLTZ;
                    5'b00001: op = OP_BGEZ;
                    5'b10000: op = OP_BLTZAL;
                    5'b10001: op = OP_BGEZAL;
                    default:  op = OP_INVALID;
                endcase
            end

            6'b0001??: begin // conditional branch
                rs1 = inst.i.rs;
                rs2 = inst.i.rt;
                unique case (inst.i.opcode[1:0])
                    2'b00: op = OP_BEQ;
                    2'b01: op = OP_BNE;
                    2'b10: op = OP_BLEZ;
                    2'b11: op = OP_BGTZ;
                endcase
            end

            6'b001???: begin // immediate alu
                rs1        = inst.i.rs;
                rd         = inst.i.rt;
                use_imm    = 1'b1;
                imm_signed = ~inst.i.opcode[2]; // logic ops zero extend
                unique case (inst.i.opcode[2:0])
                    3'b000: op = OP_ADD;
                    3'b001: op = OP_ADDU;
                    3'b010: op = OP_SLT;
                    3'b011: op = OP_SLTU;
                    3'b100: op = OP_AND;
                    3'b101: op = OP_OR;
                    3'b110: op = OP_XOR;
                    3'b111: op = OP_LUI;
                endcase
            end

            6'b100???: begin // load
                rs1     = inst.i.rs;
                rs2     = (inst.i.opcode[1:0] == 2'b10) ? inst.i.rt : '0;
                rd      = inst.i.rt;
                is_load = 1'b1;
                unique case (inst.i.opcode[2:0])
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b011:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_INVALID;
                endcase
            end

            6'b101???: begin // store
                rs1      = inst.i.rs;
                rs2      = inst.i.rt;
                is_store = 1'b1;
                unique case (inst.i.opcode[2:0])
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b011:  op = OP_SW;
                    default: op = OP_INVALID;
                endcase
            end

            6'b00001?: begin // j / jal
                rd = {$bits(reg_addr_t){inst.r.opcode[0]}};
                op = OP_JAL;
            end

            6'b010000: begin // COP0
                unique case (inst.r.rs)
                    5'b00000: begin
                        op = OP_MFC0;
                        rd = inst.r.rt;
                    end
                    5'b00100: begin
                        op  = OP_MTC0;
                        rs1 = inst.r.rt;
                    end
                    5'b10000: op = (inst.r.funct == 6'b011000) ? OP_ERET : OP_INVALID;
                    default:  op = OP_INVALID;
                endcase
            end

            default: op = OP_INVALID;
        endcase
    end

endmodule

`default_nettype wire

// File: common/decode_pkg.sv
// decode unit shared definitions
`default_nettype none

package decode_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_JALR, OP_SYSCALL, OP_BREAK,
        OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_LUI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_JAL,
        OP_MFC0, OP_MTC0, OP_ERET,
        OP_INVALID
    } op_t;

    typedef enum logic [2:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_CALL,
        CF_RETURN
    } cf_t;

    // one instruction word in register and immediate formats
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;
        } i;
    } inst_u;

    localparam logic [7:0] REG_PC           = 8'h00;
    localparam logic [7:0] REG_INST         = 8'h04; // write only
    localparam logic [7:0] REG_DEC_OP       = 8'h08;
    localparam logic [7:0] REG_DEC_REGS     = 8'h0C;
    localparam logic [7:0] REG_JUMP_I       = 8'h10;
    localparam logic [7:0] REG_JUMP_J       = 8'h14;
    localparam logic [7:0] REG_STAT_BRANCH  = 8'h18;
    localparam logic [7:0] REG_STAT_MEM     = 8'h1C;
    localparam logic [7:0] REG_STAT_INVALID = 8'h20;
    localparam logic [7:0] REG_STAT_TOTAL   = 8'h24; // write clears counters

endpackage

`default_nettype wire
